// ==== hdl/coherentDCachePkg.sv ====
package coherentDCachePkg;

  // geometry of the CPU address and of a cache line
  localparam int addrWidth = 31;
  localparam int dataWidth = 32;
  localparam int wordsPerLine = 8;
  localparam int offsetBits = 3;
  localparam int coreIdWidth = 4;

  // slot types seen on the ring
  typedef enum logic [3:0] {
    slotToken = 4'd1,
    slotAddress = 4'd2,
    slotWriteData = 4'd3,
    slotNull = 4'd7
  } slotType_t;

  typedef enum logic [1:0] {
    lineInvalid = 2'd0,
    lineShared = 2'd1,
    lineModified = 2'd3
  } lineState_t;

  // one access walks these in order, skipping what it does not need
  typedef enum logic [3:0] {
    phaseIdle,
    phaseLookup,
    phaseWaitToken,
    phaseWaitTrain,
    phaseSendRead,
    phaseSendData,
    phaseSendWriteback,
    phaseWaitFill,
    phaseComplete
  } ctrlPhase_t;

endpackage

// ==== hdl/ringReceiver.sv ====
`timescale 1ns/1ps

module ringReceiver (
  input  logic clock,
  input  logic reset,
  input  logic [coherentDCachePkg::coreIdWidth-1:0] coreId,
  input  coherentDCachePkg::slotType_t slotTypeIn,
  input  logic [coherentDCachePkg::dataWidth-1:0] ringIn,
  input  logic [coherentDCachePkg::dataWidth-1:0] rdReturn,
  input  logic [coherentDCachePkg::coreIdWidth-1:0] rdDest,
  input  logic fillActive,
  output logic tokenSeen,
  output logic [7:0] trainLength,
  output logic fillWrite,
  output logic [coherentDCachePkg::offsetBits-1:0] fillOffset,
  output logic [coherentDCachePkg::dataWidth-1:0] fillData,
  output logic fillDone
);
  import coherentDCachePkg::*;

  logic [offsetBits-1:0] beatCount;

  // token word carries the pending train length in its low byte
  assign tokenSeen = (slotTypeIn == slotToken);
  assign trainLength = ringIn[7:0];

  // beats for other cores share the return ring and are ignored
  assign fillWrite = fillActive && (rdDest == coreId);
  assign fillOffset = beatCount;
  assign fillData = rdReturn;
  assign fillDone = fillWrite && (beatCount == offsetBits'(wordsPerLine - 1));

  // wraps back to zero after the last word of the line
  always_ff @(posedge clock) begin
    if (reset) begin
      beatCount <= '0;
    end else if (fillWrite) begin
      beatCount <= beatCount + 1'b1;
    end
  end

endmodule

// ==== hdl/lineStateStore.sv ====
`timescale 1ns/1ps

module lineStateStore #(
  parameter int indexBits = 7
) (
  input  logic clock,
  input  logic reset,
  input  logic [indexBits-1:0] index,
  input  logic writeTag,
  input  logic [coherentDCachePkg::addrWidth - indexBits
                - coherentDCachePkg::offsetBits - 1:0] tagIn,
  input  logic writeState,
  input  coherentDCachePkg::lineState_t stateIn,
  output logic [coherentDCachePkg::addrWidth - indexBits
                - coherentDCachePkg::offsetBits - 1:0] tagOut,
  output coherentDCachePkg::lineState_t stateOut
);
  import coherentDCachePkg::*;

  localparam int tagWidth = addrWidth - indexBits - offsetBits;
  localparam int lineCount = 2 ** indexBits;

  logic [tagWidth-1:0] tags [lineCount];
  lineState_t states [lineCount];

  always_ff @(posedge clock) begin
    if (writeTag) begin
      tags[index] <= tagIn;
    end
  end

  // every line comes out of reset invalid
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < lineCount; i++) begin
        states[i] <= lineInvalid;
      end
    end else if (writeState) begin
      states[index] <= stateIn;
    end
  end

  // lookup port reads in the same cycle
  assign tagOut = tags[index];
  assign stateOut = states[index];

endmodule

// ==== hdl/dataArray.sv ====
`timescale 1ns/1ps

module dataArray #(
  parameter int indexBits = 7
) (
  input  logic clock,
  input  logic [indexBits+coherentDCachePkg::offsetBits-1:0] cpuAddr,
  input  logic cpuWrite,
  input  logic [coherentDCachePkg::dataWidth-1:0] cpuData,
  input  logic [indexBits+coherentDCachePkg::offsetBits-1:0] fillAddr,
  input  logic fillWrite,
  input  logic [coherentDCachePkg::dataWidth-1:0] fillData,
  output logic [coherentDCachePkg::dataWidth-1:0] readData
);
  import coherentDCachePkg::*;

  localparam int wordCount = 2 ** (indexBits + offsetBits);

  logic [dataWidth-1:0] words [wordCount];
  logic [indexBits+offsetBits-1:0] readAddr;

  // port A serves the CPU and the victim reads, port B the fill
  always_ff @(posedge clock) begin
    readAddr <= cpuAddr;
    if (cpuWrite) begin
      words[cpuAddr] <= cpuData;
    end
    if (fillWrite) begin
      words[fillAddr] <= fillData;
    end
  end

  // registered address gives one cycle of read latency
  assign readData = words[readAddr];

endmodule

// ==== hdl/missController.sv ====
`timescale 1ns/1ps

module missController #(
  parameter int indexBits = 7
) (
  input  logic clock,
  input  logic reset,
  input  logic [coherentDCachePkg::addrWidth-1:0] aq,
  input  logic read,
  input  logic selDCache,
  input  logic [coherentDCachePkg::addrWidth - indexBits
                - coherentDCachePkg::offsetBits - 1:0] tagOut,
  input  coherentDCachePkg::lineState_t stateOut,
  input  logic tokenSeen,
  input  logic [7:0] trainLength,
  input  logic fillDone,
  output coherentDCachePkg::ctrlPhase_t phase,
  output logic [indexBits-1:0] index,
  output logic writeTag,
  output logic writeState,
  output coherentDCachePkg::lineState_t stateIn,
  output logic [indexBits+coherentDCachePkg::offsetBits-1:0] cpuAddr,
  output logic cpuWrite,
  output logic fillActive,
  output logic exclusive,
  output logic dirtyFlush,
  output logic [27:0] victimLine,
  output logic [coherentDCachePkg::offsetBits-1:0] flushOffset,
  output logic done,
  output logic wrq,
  output logic rwq
);
  import coherentDCachePkg::*;

  localparam int lineBits = indexBits + offsetBits;

  ctrlPhase_t nextPhase;
  logic [7:0] trainCount;
  logic settle;
  logic hit;
  logic [offsetBits-1:0] readOffset;

  assign index = aq[lineBits-1:offsetBits];

  // a write only hits a line it already owns
  assign hit = (tagOut == aq[addrWidth-1:lineBits]) &&
               (read ? (stateOut != lineInvalid) : (stateOut == lineModified));

  // victim words are addressed one cycle ahead of the slot that carries them
  always_comb begin
    if (phase == phaseSendRead) begin
      readOffset = '0;
    end else if (phase == phaseSendData) begin
      readOffset = flushOffset + 1'b1;
    end else begin
      readOffset = aq[offsetBits-1:0];
    end
  end
  assign cpuAddr = {index, readOffset};

  assign done = (phase == phaseComplete);
  assign wrq = done && read;
  assign rwq = done && !read;
  assign cpuWrite = done && !read;
  assign fillActive = (phase == phaseWaitFill) && !settle;

  always_comb begin
    writeTag = 1'b0;
    writeState = 1'b0;
    stateIn = lineInvalid;
    if (phase == phaseLookup && !hit) begin
      // new tag goes in at once and the line stays unusable until filled
      writeTag = 1'b1;
      writeState = 1'b1;
      stateIn = read ? lineShared : lineInvalid;
    end else if (done && !read) begin
      writeState = 1'b1;
      stateIn = lineModified;
    end
  end

  always_comb begin
    nextPhase = phase;
    case (phase)
      phaseIdle: begin
        if (selDCache) nextPhase = phaseLookup;
      end
      phaseLookup: begin
        nextPhase = hit ? phaseComplete : phaseWaitToken;
      end
      phaseWaitToken: begin
        if (tokenSeen) begin
          nextPhase = (trainLength == 8'd0) ? phaseSendRead : phaseWaitTrain;
        end
      end
      phaseWaitTrain: begin
        if (trainCount == 8'd1) nextPhase = phaseSendRead;
      end
      phaseSendRead: begin
        nextPhase = dirtyFlush ? phaseSendData : phaseWaitFill;
      end
      phaseSendData: begin
        if (flushOffset == offsetBits'(wordsPerLine - 1)) nextPhase = phaseSendWriteback;
      end
      phaseSendWriteback: begin
        nextPhase = phaseWaitFill;
      end
      phaseWaitFill: begin
        if (settle) nextPhase = phaseComplete;
      end
      default: begin
        nextPhase = phaseIdle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      phase <= phaseIdle;
      trainCount <= '0;
      flushOffset <= '0;
      settle <= 1'b0;
      exclusive <= 1'b0;
      dirtyFlush <= 1'b0;
    end else begin
      phase <= nextPhase;
      // one spare cycle after the last fill word
      settle <= fillDone;
      if (phase == phaseLookup) begin
        exclusive <= !read;
        dirtyFlush <= (stateOut == lineModified);
        flushOffset <= '0;
      end else if (phase == phaseSendData) begin
        flushOffset <= flushOffset + 1'b1;
      end
      if (phase == phaseWaitToken && tokenSeen) begin
        trainCount <= trainLength;
      end else if (phase == phaseWaitTrain) begin
        trainCount <= trainCount - 1'b1;
      end
    end
  end

  // old tag and index of the line being replaced
  always_ff @(posedge clock) begin
    if (phase == phaseLookup) begin
      victimLine <= {tagOut, index};
    end
  end

endmodule

// ==== hdl/ringTransmitter.sv ====
`timescale 1ns/1ps

module ringTransmitter (
  input  coherentDCachePkg::ctrlPhase_t phase,
  input  logic [coherentDCachePkg::coreIdWidth-1:0] coreId,
  input  logic [coherentDCachePkg::dataWidth-1:0] ringIn,
  input  coherentDCachePkg::slotType_t slotTypeIn,
  input  logic [coherentDCachePkg::coreIdWidth-1:0] srcDestIn,
  input  logic tokenSeen,
  input  logic [coherentDCachePkg::addrWidth-1:0] aq,
  input  logic exclusive,
  input  logic dirtyFlush,
  input  logic [27:0] victimLine,
  input  logic [coherentDCachePkg::dataWidth-1:0] readData,
  output logic [coherentDCachePkg::dataWidth-1:0] dcRingOut,
  output coherentDCachePkg::slotType_t dcSlotTypeOut,
  output logic [coherentDCachePkg::coreIdWidth-1:0] dcSrcDestOut,
  output logic dcDriveRing
);
  import coherentDCachePkg::*;

  always_comb begin
    dcRingOut = ringIn;
    dcSlotTypeOut = slotTypeIn;
    dcSrcDestOut = srcDestIn;
    dcDriveRing = 1'b0;
    case (phase)
      phaseWaitToken: begin
        dcDriveRing = 1'b1;
        // claim slots for the request, plus data and write-back if dirty
        if (tokenSeen) begin
          dcRingOut = ringIn + (dirtyFlush ? dataWidth'(10) : dataWidth'(1));
        end
      end
      phaseSendRead: begin
        dcDriveRing = 1'b1;
        dcSlotTypeOut = slotAddress;
        dcSrcDestOut = coreId;
        dcRingOut = {2'b00, exclusive, 1'b1, aq[addrWidth-1:offsetBits]};
      end
      phaseSendData: begin
        dcDriveRing = 1'b1;
        dcSlotTypeOut = slotWriteData;
        dcSrcDestOut = coreId;
        dcRingOut = readData;
      end
      phaseSendWriteback: begin
        dcDriveRing = 1'b1;
        dcSlotTypeOut = slotAddress;
        dcSrcDestOut = coreId;
        dcRingOut = {4'b0000, victimLine};
      end
      default: begin
        dcDriveRing = 1'b0;
      end
    endcase
  end

endmodule

// ==== hdl/coherentDCache.sv ====
`timescale 1ns/1ps

module coherentDCache #(
  parameter int indexBits = 7
) (
  input  logic clock,
  input  logic reset,
  input  logic [coherentDCachePkg::coreIdWidth-1:0] coreId,
  input  logic [coherentDCachePkg::addrWidth-1:0] aq,
  input  logic read,
  input  logic [coherentDCachePkg::dataWidth-1:0] wq,
  input  logic selDCache,
  input  logic [coherentDCachePkg::dataWidth-1:0] ringIn,
  input  coherentDCachePkg::slotType_t slotTypeIn,
  input  logic [coherentDCachePkg::coreIdWidth-1:0] srcDestIn,
  input  logic [coherentDCachePkg::dataWidth-1:0] rdReturn,
  input  logic [coherentDCachePkg::coreIdWidth-1:0] rdDest,
  output logic [coherentDCachePkg::dataWidth-1:0] rqDCache,
  output logic wrq,
  output logic rwq,
  output logic done,
  output logic [coherentDCachePkg::dataWidth-1:0] dcRingOut,
  output coherentDCachePkg::slotType_t dcSlotTypeOut,
  output logic [coherentDCachePkg::coreIdWidth-1:0] dcSrcDestOut,
  output logic dcDriveRing
);
  import coherentDCachePkg::*;

  localparam int lineBits = indexBits + offsetBits;

  ctrlPhase_t phase;
  logic tokenSeen;
  logic [7:0] trainLength;
  logic fillWrite;
  logic [offsetBits-1:0] fillOffset;
  logic [dataWidth-1:0] fillData;
  logic fillDone;
  logic fillActive;
  logic [indexBits-1:0] index;
  logic writeTag;
  logic writeState;
  lineState_t stateIn;
  lineState_t stateOut;
  logic [addrWidth-lineBits-1:0] tagOut;
  logic [lineBits-1:0] cpuAddr;
  logic cpuWrite;
  logic exclusive;
  logic dirtyFlush;
  logic [27:0] victimLine;

  ringReceiver receiver_i (
    .clock, .reset, .coreId, .slotTypeIn, .ringIn, .rdReturn, .rdDest, .fillActive,
    .tokenSeen, .trainLength, .fillWrite, .fillOffset, .fillData, .fillDone
  );

  missController #(.indexBits(indexBits)) controller_i (
    .clock, .reset, .aq, .read, .selDCache, .tagOut, .stateOut,
    .tokenSeen, .trainLength, .fillDone,
    .phase, .index, .writeTag, .writeState, .stateIn, .cpuAddr, .cpuWrite,
    .fillActive, .exclusive, .dirtyFlush, .victimLine, .flushOffset(),
    .done, .wrq, .rwq
  );

  // the new tag is always the upper part of the CPU address
  lineStateStore #(.indexBits(indexBits)) store_i (
    .clock, .reset, .index, .writeTag,
    .tagIn(aq[addrWidth-1:lineBits]),
    .writeState, .stateIn, .tagOut, .stateOut
  );

  dataArray #(.indexBits(indexBits)) data_i (
    .clock, .cpuAddr, .cpuWrite,
    .cpuData(wq),
    .fillAddr({index, fillOffset}),
    .fillWrite, .fillData,
    .readData(rqDCache)
  );

  ringTransmitter transmitter_i (
    .phase, .coreId, .ringIn, .slotTypeIn, .srcDestIn, .tokenSeen, .aq,
    .exclusive, .dirtyFlush, .victimLine,
    .readData(rqDCache),
    .dcRingOut, .dcSlotTypeOut, .dcSrcDestOut, .dcDriveRing
  );

endmodule

// ==== sim/coherentDCache_tb.sv ====
`timescale 1ns/1ps

module coherentDCache_tb;
  import coherentDCachePkg::*;

  localparam int indexBits = 7;
  localparam int directedCount = 10;
  localparam int randomCount = 40;
  localparam int accessCount = directedCount + randomCount;
  localparam int watchdogCycles = accessCount * 200 + 2000;
  localparam int accessLimit = 150;
  localparam logic [3:0] coreIdValue = 4'd5;
  localparam logic [3:0] idleDest = 4'd0;
  localparam logic [3:0] foreignDest = 4'd9;

  logic clock;
  logic reset;
  logic [3:0] coreId;
  logic [30:0] aq;
  logic read;
  logic [31:0] wq;
  logic selDCache;
  logic [31:0] ringIn;
  slotType_t slotTypeIn;
  logic [3:0] srcDestIn;
  logic [31:0] rdReturn;
  logic [3:0] rdDest;
  logic [31:0] rqDCache;
  logic wrq;
  logic rwq;
  logic done;
  logic [31:0] dcRingOut;
  slotType_t dcSlotTypeOut;
  logic [3:0] dcSrcDestOut;
  logic dcDriveRing;

  // memory model, CPU write shadow and reference line states
  logic [31:0] memory [4096];
  bit memValid [4096];
  logic [31:0] shadow [4096];
  bit shadowValid [4096];
  logic [20:0] refTag [128];
  lineState_t refState [128];

  // the access in flight and what it should look like
  bit pending;
  bit accessDone;
  bit expHit;
  bit expDirty;
  logic [27:0] expVictimLine;
  logic [30:0] reqAddr;
  logic reqRead;
  logic [31:0] reqData;
  int reqCycle;

  // slots the cache put on the ring for this access
  slotType_t logType [$];
  logic [31:0] logWord [$];
  logic [3:0] logSrc [$];
  logic [31:0] wbBuffer [8];
  int wbCount;
  int tokensTaken;
  int takeCycle;
  logic [7:0] takeTrain;

  // ring and return ring model state
  int cycleCount;
  logic [7:0] trainNext;
  bit seqActive;
  logic [27:0] seqLine;
  int lastSlotCycle;
  bit returnPending;
  logic [27:0] returnLine;
  int returnStart;
  int lastFillCycle;
  int beat;
  int off;

  int seed;
  int checks;
  int valueErrors;
  int protocolErrors;

  coherentDCache #(.indexBits(indexBits)) dut_i (
    .clock, .reset, .coreId, .aq, .read, .wq, .selDCache,
    .ringIn, .slotTypeIn, .srcDestIn, .rdReturn, .rdDest,
    .rqDCache, .wrq, .rwq, .done,
    .dcRingOut, .dcSlotTypeOut, .dcSrcDestOut, .dcDriveRing
  );

  always #10 clock = ~clock;

  function automatic logic [30:0] makeAddr(input logic [1:0] tag, input logic [6:0] idx,
                                           input logic [2:0] offset);
    return {19'd0, tag, idx, offset};
  endfunction

  // every address bit feeds the initial memory pattern
  function automatic logic [31:0] hashWord(input logic [30:0] addr);
    logic [31:0] mixed;
    mixed = {1'b0, addr} * 32'h9E3779B1;
    return mixed ^ {addr[15:0], addr[30:15]} ^ 32'h0F0F3C3C;
  endfunction

  function automatic logic [31:0] memoryWord(input logic [30:0] addr);
    if (memValid[addr[11:0]]) begin
      return memory[addr[11:0]];
    end
    return hashWord(addr);
  endfunction

  // reference value of a word as the CPU should see it
  function automatic logic [31:0] expectedWord(input logic [30:0] addr);
    if (shadowValid[addr[11:0]]) begin
      return shadow[addr[11:0]];
    end
    return memoryWord(addr);
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] observed);
    $display("Fail at %0t ns: %s expected %h observed %h", $time, name, expected, observed);
    valueErrors++;
  endtask

  task automatic reportProblem(input string text);
    $display("Error at %0t ns: %s", $time, text);
    protocolErrors++;
  endtask

  task automatic applyWriteback(input logic [27:0] line);
    logic [30:0] wordAddr;
    if (wbCount != 8) begin
      reportProblem($sformatf("write-back address after %0d data words instead of 8", wbCount));
    end else begin
      for (int k = 0; k < 8; k++) begin
        wordAddr = {line, 3'(k)};
        memory[wordAddr[11:0]] = wbBuffer[k];
        memValid[wordAddr[11:0]] = 1'b1;
      end
    end
  endtask

  // token handling, slot log and the end of each miss sequence
  task automatic watchRing();
    int increment;
    bit isSlot;
    isSlot = (dcDriveRing === 1'b1) &&
             (dcSlotTypeOut == slotAddress || dcSlotTypeOut == slotWriteData);
    if (dcDriveRing === 1'b0) begin
      if (dcRingOut !== ringIn) reportMismatch("dcRingOut", ringIn, dcRingOut);
      if (dcSlotTypeOut !== slotTypeIn) begin
        reportMismatch("dcSlotTypeOut", 32'(slotTypeIn), 32'(dcSlotTypeOut));
      end
      if (dcSrcDestOut !== srcDestIn) begin
        reportMismatch("dcSrcDestOut", 32'(srcDestIn), 32'(dcSrcDestOut));
      end
    end else if (pending && expHit) begin
      reportProblem("the cache drove the ring during a hit");
    end
    if (dcDriveRing === 1'b1 && slotTypeIn == slotToken && dcSlotTypeOut == slotToken) begin
      increment = expDirty ? 10 : 1;
      if (dcRingOut !== ringIn + 32'(increment)) begin
        reportMismatch("dcRingOut token", ringIn + 32'(increment), dcRingOut);
      end
      tokensTaken++;
      takeCycle = cycleCount;
      takeTrain = ringIn[7:0];
    end
    if (isSlot) begin
      logType.push_back(dcSlotTypeOut);
      logWord.push_back(dcRingOut);
      logSrc.push_back(dcSrcDestOut);
      lastSlotCycle = cycleCount;
      if (dcSlotTypeOut == slotWriteData) begin
        if (wbCount < 8) wbBuffer[wbCount] = dcRingOut;
        wbCount++;
      end else if (dcRingOut[28]) begin
        seqActive = 1'b1;
        seqLine = dcRingOut[27:0];
        if (cycleCount - takeCycle != int'(takeTrain) + 1) begin
          reportProblem($sformatf("read request %0d cycles after the token with train %0d",
                                  cycleCount - takeCycle, takeTrain));
        end
      end else begin
        applyWriteback(dcRingOut[27:0]);
      end
    end else if (seqActive) begin
      seqActive = 1'b0;
      returnLine = seqLine;
      returnStart = lastSlotCycle + 6;
      returnPending = 1'b1;
    end
  endtask

  task automatic checkSlot(input int pos, input slotType_t kind, input logic [31:0] word,
                           input string what);
    if (logType[pos] != kind) begin
      reportProblem($sformatf("slot %0d of the miss should be the %s slot", pos, what));
    end else if (logSrc[pos] !== coreIdValue) begin
      reportMismatch("dcSrcDestOut", 32'(coreIdValue), 32'(logSrc[pos]));
    end else if (logWord[pos] !== word) begin
      reportMismatch({"dcRingOut ", what}, word, logWord[pos]);
    end
  endtask

  task automatic checkCompletion();
    logic [6:0] idx;
    logic [30:0] victimAddr;
    idx = reqAddr[9:3];
    checks++;
    if (reqRead) begin
      if (wrq !== 1'b1 || rwq !== 1'b0) reportProblem("a read ended without wrq alone high");
      if (rqDCache !== expectedWord(reqAddr)) begin
        reportMismatch("rqDCache", expectedWord(reqAddr), rqDCache);
      end
    end else if (rwq !== 1'b1 || wrq !== 1'b0) begin
      reportProblem("a write ended without rwq alone high");
    end
    if (expHit) begin
      if (cycleCount - reqCycle != 2) begin
        reportProblem($sformatf("hit took %0d cycles instead of 2", cycleCount - reqCycle));
      end
    end else begin
      if (tokensTaken != 1) reportProblem($sformatf("miss took %0d tokens", tokensTaken));
      if (cycleCount - lastFillCycle != 2) begin
        reportProblem($sformatf("done came %0d cycles after the last fill word",
                                cycleCount - lastFillCycle));
      end
      if (logWord.size() != (expDirty ? 10 : 1)) begin
        reportProblem($sformatf("miss sent %0d slots", logWord.size()));
      end else begin
        checkSlot(0, slotAddress, {2'b00, !reqRead, 1'b1, reqAddr[30:3]}, "read request");
        if (expDirty) begin
          for (int k = 0; k < 8; k++) begin
            victimAddr = {expVictimLine, 3'(k)};
            checkSlot(k + 1, slotWriteData, expectedWord(victimAddr), "victim data");
          end
          checkSlot(9, slotAddress, {4'b0000, expVictimLine}, "write-back");
        end
      end
    end
    refTag[idx] = reqAddr[30:10];
    if (!reqRead) begin
      refState[idx] = lineModified;
      shadow[reqAddr[11:0]] = reqData;
      shadowValid[reqAddr[11:0]] = 1'b1;
    end else if (!expHit) begin
      refState[idx] = lineShared;
    end
    pending = 1'b0;
    accessDone = 1'b1;
  endtask

  task automatic runAccess(input logic [30:0] addr, input logic isRead, input logic [31:0] data);
    logic [6:0] idx;
    int waited;
    idx = addr[9:3];
    // a write only hits a modified line
    expHit = (refTag[idx] == addr[30:10]) &&
             (isRead ? (refState[idx] != lineInvalid) : (refState[idx] == lineModified));
    expDirty = !expHit && (refState[idx] == lineModified);
    expVictimLine = {refTag[idx], idx};
    reqAddr = addr;
    reqRead = isRead;
    reqData = data;
    logType.delete();
    logWord.delete();
    logSrc.delete();
    tokensTaken = 0;
    wbCount = 0;
    accessDone = 1'b0;
    @(posedge clock);
    #2;
    aq = addr;
    read = isRead;
    wq = data;
    selDCache = 1'b1;
    reqCycle = cycleCount;
    pending = 1'b1;
    waited = 0;
    while (!accessDone && waited < accessLimit) begin
      @(posedge clock);
      waited++;
    end
    #2;
    selDCache = 1'b0;
    if (!accessDone) begin
      reportProblem($sformatf("no done within %0d cycles for address %h", accessLimit, addr));
      pending = 1'b0;
    end
  endtask

  // ring slots and read-return beats with a token every 40 cycles
  always begin
    @(posedge clock);
    cycleCount++;
    #2;
    if (cycleCount % 40 == 0) begin
      slotTypeIn = slotToken;
      ringIn = {24'h0, trainNext};
      trainNext = (trainNext == 8'd0) ? 8'd3 : 8'd0;
    end else begin
      slotTypeIn = slotNull;
      ringIn = '0;
    end
    srcDestIn = 4'd0;
    rdDest = idleDest;
    rdReturn = '0;
    if (returnPending && cycleCount >= returnStart) begin
      beat = cycleCount - returnStart;
      if (beat == 4) begin
        // beat for another core in the middle of the line
        rdDest = foreignDest;
        rdReturn = 32'hDEAD0000 | 32'(beat);
      end else begin
        off = (beat < 4) ? beat : beat - 1;
        rdDest = coreIdValue;
        rdReturn = memoryWord({returnLine, 3'(off)});
        if (beat == 8) begin
          returnPending = 1'b0;
          lastFillCycle = cycleCount;
        end
      end
    end
  end

  // compares every cycle at mid-period where the outputs are settled
  always @(negedge clock) begin
    if (reset === 1'b0) begin
      watchRing();
      if (!pending) begin
        if (done !== 1'b0 || wrq !== 1'b0 || rwq !== 1'b0 || dcDriveRing !== 1'b0) begin
          reportProblem("done, wrq, rwq or dcDriveRing high with no access pending");
        end
      end else if (done === 1'b1) begin
        checkCompletion();
      end else if (wrq !== 1'b0 || rwq !== 1'b0) begin
        reportProblem("wrq or rwq high before done");
      end
    end
  end

  initial begin
    repeat (watchdogCycles) @(posedge clock);
    $display("watchdog expired after %0d cycles with accesses still running", watchdogCycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [30:0] addrA;
    logic [30:0] addrB;
    logic [30:0] addrB2;
    logic [30:0] addrC;
    logic [30:0] randAddr;
    clock = 1'b0;
    reset = 1'b1;
    coreId = coreIdValue;
    aq = '0;
    read = 1'b0;
    wq = '0;
    selDCache = 1'b0;
    ringIn = '0;
    slotTypeIn = slotNull;
    srcDestIn = '0;
    rdReturn = '0;
    rdDest = idleDest;
    trainNext = 8'd0;
    seed = 61859;
    for (int i = 0; i < 4096; i++) begin
      memValid[i] = 1'b0;
      shadowValid[i] = 1'b0;
    end
    for (int i = 0; i < 128; i++) begin
      refTag[i] = '0;
      refState[i] = lineInvalid;
    end
    repeat (16) @(posedge clock);
    #2;
    reset = 1'b0;
    repeat (4) @(posedge clock);

    addrA = makeAddr(2'd0, 7'd5, 3'd2);
    addrB = makeAddr(2'd1, 7'd9, 3'd4);
    addrB2 = makeAddr(2'd1, 7'd9, 3'd6);
    addrC = makeAddr(2'd2, 7'd9, 3'd1);
    // clean read miss, then a hit on the same word
    runAccess(addrA, 1'b1, 32'h0);
    runAccess(addrA, 1'b1, 32'h0);
    // write miss, write hits and read back
    runAccess(addrB, 1'b0, 32'hCAFE0001);
    runAccess(addrB, 1'b0, 32'hCAFE0002);
    runAccess(addrB2, 1'b0, 32'hBEEF0006);
    runAccess(addrB, 1'b1, 32'h0);
    // conflicting tag flushes the modified line, then it comes back from memory
    runAccess(addrC, 1'b1, 32'h0);
    runAccess(addrB, 1'b1, 32'h0);
    runAccess(addrB2, 1'b1, 32'h0);
    // write to a shared line needs an exclusive read
    runAccess(addrA, 1'b0, 32'h12345678);

    for (int n = 0; n < randomCount; n++) begin
      randAddr = makeAddr(2'($random(seed)), 7'(8 + ($random(seed) & 3)), 3'($random(seed)));
      runAccess(randAddr, 1'($random(seed)), $random(seed));
    end

    repeat (10) @(posedge clock);
    $display("checks %0d, value errors %0d, protocol errors %0d",
             checks, valueErrors, protocolErrors);
    if (valueErrors == 0 && protocolErrors == 0 && checks == accessCount) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== coherentDCache.f ====
hdl/coherentDCachePkg.sv
hdl/ringReceiver.sv
hdl/lineStateStore.sv
hdl/dataArray.sv
hdl/missController.sv
hdl/ringTransmitter.sv
hdl/coherentDCache.sv
sim/coherentDCache_tb.sv

// ==== Bender.yml ====
package:
  name: coherentDCache

sources:
  - files:
      - hdl/coherentDCachePkg.sv
      - hdl/ringReceiver.sv
      - hdl/lineStateStore.sv
      - hdl/dataArray.sv
      - hdl/missController.sv
      - hdl/ringTransmitter.sv
      - hdl/coherentDCache.sv
  - target: simulation
    files:
      - sim/coherentDCache_tb.sv
